//--- cr16Top.f
cr16Pkg.sv
instQueue.sv
instDecoder.sv
execCore.sv
cr16AxiSlave.sv
cr16Top.sv
cr16Top_assert.sv
tbCr16Top.sv

//--- tbCr16Top.sv
`timescale 1ns/1ps

module tbCr16Top;
	import cr16Pkg::*;

	typedef struct packed {
		instWord inst;
		logic check;
	} progRow;

	logic clk = 1'b0;
	logic arstN;
	logic [axiAddrWidth-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [axiDataWidth-1:0] wdata;
	logic [axiDataWidth/8-1:0] wstrb;
	logic wvalid;
	logic wready;
	axiResp bresp;
	logic bvalid;
	logic bready;
	logic [axiAddrWidth-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [axiDataWidth-1:0] rdata;
	axiResp rresp;
	logic rvalid;
	logic rready;

	progRow progTable [$];
	logic [dataWidth-1:0] modelReg [regCount];
	logic [dataWidth-1:0] modelMem [memDepth];
	string testNames [6] = '{"literals", "immediates", "register alu", "shifts",
		"load and store", "burst"};
	integer seed = 88765;
	int cycles = 0;
	int cycleLimit = 100000;
	int checks = 0;
	int errors = 0;
	int errorsBefore;
	int idx;
	int testNum;
	int checkPoints;
	logic writing;

	cr16Top DUT (.*);

	bind cr16Top cr16TopAssert handshakeChecks (
		.clk(clk),
		.arstN(arstN),
		.bvalid(bvalid),
		.bready(bready),
		.rvalid(rvalid),
		.rready(rready),
		.pushValid(pushValid),
		.full(full),
		.pop(pop),
		.empty(empty)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycleLimit) begin
			$display("timeout, run stopped after %0d cycles", cycles);
			$display("Something failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// instruction builders

	function automatic instWord regInst(input logic [3:0] op, input logic [3:0] dest,
			input logic [3:0] ext, input logic [3:0] src);
		instWord w;
		w.r.cls = 2'b00;
		w.r.op = op;
		w.r.dest = dest;
		w.r.ext = ext;
		w.r.src = src;
		return w;
	endfunction

	function automatic instWord immInst(input logic [3:0] op, input logic [3:0] dest,
			input logic [7:0] imm);
		instWord w;
		w.i.cls = 2'b00;
		w.i.op = op;
		w.i.dest = dest;
		w.i.imm = imm;
		return w;
	endfunction

	// bits 11:8 of a literal double as its destination
	function automatic instWord litInst(input logic [15:0] value);
		instWord w;
		w.i.cls = 2'b11;
		w.i.op = value[15:12];
		w.i.dest = value[11:8];
		w.i.imm = value[7:0];
		return w;
	endfunction

	function automatic logic [7:0] randByte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	task automatic addRow(input instWord w, input logic check);
		progRow row;
		row.inst = w;
		row.check = check;
		progTable.push_back(row);
	endtask

	task automatic buildProgram();
		// literals and loads of immediates
		addRow(immInst(opMovi, 1, 8'hA5), 0);
		addRow(immInst(opLui, 2, 8'h3C), 0);
		addRow(litInst(16'hB3EF), 0);
		addRow(immInst(opMovi, 4, randByte()), 1);
		// extension of immediates, compares
		addRow(immInst(opAddi, 1, 8'hF0), 0);
		addRow(immInst(opSubi, 2, 8'hFE), 0);
		addRow(immInst(opAddui, 3, 8'hF0), 0);
		addRow(immInst(opCmpui, 4, 8'hFF), 0);
		addRow(immInst(opCmpi, 1, 8'h80), 0);
		addRow(regInst(opRtype, 2, extCmp, 3), 0);
		addRow(immInst(opAddci, 5, randByte()), 0);
		addRow(immInst(opAddcui, 6, 8'h81), 1);
		// register alu
		addRow(regInst(opRtype, 6, extMov, 3), 0);
		addRow(regInst(opRtype, 6, extAnd, 2), 0);
		addRow(regInst(opRtype, 7, extMov, 2), 0);
		addRow(regInst(opRtype, 7, extOr, 4), 0);
		addRow(regInst(opRtype, 8, extMov, 1), 0);
		addRow(regInst(opRtype, 8, extXor, 3), 0);
		addRow(regInst(opRtype, 9, extMov, 2), 0);
		addRow(regInst(opRtype, 9, extAdd, 3), 0);
		addRow(regInst(opRtype, 9, extAddc, 1), 0);
		addRow(regInst(opRtype, 10, extMov, 1), 0);
		addRow(regInst(opRtype, 10, extSub, 2), 0);
		addRow(regInst(opRtype, 11, extNot, 3), 1);
		// shifts, r15 holds a count of -3
		addRow(regInst(opRtype, 12, extMov, 3), 0);
		addRow(regInst(opShift, 12, extLshi, 3), 0);
		addRow(litInst(16'hFFFD), 0);
		addRow(regInst(opRtype, 14, extMov, 3), 0);
		addRow(regInst(opShift, 14, extLsh, 15), 0);
		addRow(immInst(opMovi, 13, 8'h02), 0);
		addRow(regInst(opShift, 12, extLsh, 13), 0);
		addRow(litInst(16'h85F0), 0);
		addRow(immInst(opMovi, 13, 8'h04), 0);
		addRow(regInst(opShift, 5, extArsh, 13), 1);
		// store through r7, load back into r8
		addRow(immInst(opMovi, 6, 8'h07), 0);
		addRow(litInst(16'h1734), 0);
		addRow(regInst(opMem, 7, extStor, 6), 0);
		addRow(regInst(opMem, 8, extLoad, 6), 0);
		addRow(immInst(opMovi, 9, 8'h03), 0);
		addRow(regInst(opMem, 10, extLoad, 9), 1);
		// burst of twelve
		for (int k = 0; k < 12; k++) begin
			case (k % 4)
				0: addRow(immInst(opMovi, k + 1, randByte()), 0);
				1: addRow(immInst(opAddi, k + 1, randByte()), 0);
				2: addRow(regInst(opRtype, k + 1, extAdd, (k + 5) % 16), 0);
				default: addRow(regInst(opRtype, k + 1, extXor, (k + 7) % 16), k == 11);
			endcase
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// reference model

	task automatic applyModel(input instWord w);
		logic [dataWidth-1:0] a;
		logic [dataWidth-1:0] b;
		logic [dataWidth-1:0] immS;
		logic [dataWidth-1:0] immU;
		logic [dataWidth-1:0] mag;
		a = modelReg[w.r.dest];
		b = modelReg[w.r.src];
		immS = {{8{w.i.imm[7]}}, w.i.imm};
		immU = {8'h00, w.i.imm};
		mag = b[15] ? -b : b;
		if (w.r.cls == 2'b11) begin
			modelReg[w.r.dest] = w[15:0];
		end else if (w.r.cls == 2'b00) begin
			case (w.r.op)
				opRtype: begin
					case (w.r.ext)
						extAdd, extAddu, extAddc, extAddcu: modelReg[w.r.dest] = a + b;
						extSub: modelReg[w.r.dest] = a - b;
						extAnd: modelReg[w.r.dest] = a & b;
						extOr: modelReg[w.r.dest] = a | b;
						extXor: modelReg[w.r.dest] = a ^ b;
						extNot: modelReg[w.r.dest] = ~b;
						extMov: modelReg[w.r.dest] = b;
						default: ;
					endcase
				end
				opShift: begin
					case (w.r.ext)
						extLshi: modelReg[w.r.dest] = a << w.r.src;
						extLsh: modelReg[w.r.dest] = b[15] ? a >> mag : a << b;
						extArsh: modelReg[w.r.dest] = $signed(a) >>> b;
						default: ;
					endcase
				end
				opMem: begin
					if (w.r.ext == extLoad) begin
						modelReg[w.r.dest] = modelMem[b[3:0]];
					end else if (w.r.ext == extStor) begin
						modelMem[b[3:0]] = a;
					end
				end
				opAddi, opAddci: modelReg[w.i.dest] = a + immS;
				opAddui, opAddcui: modelReg[w.i.dest] = a + immU;
				opSubi: modelReg[w.i.dest] = a - immS;
				opMovi: modelReg[w.i.dest] = immU;
				opLui: modelReg[w.i.dest] = {w.i.imm, 8'h00};
				default: ;
			endcase
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// host bus transfers, each response left waiting a cycle before it is taken

	task automatic axiWrite(input logic [axiAddrWidth-1:0] addr,
			input logic [axiDataWidth-1:0] data);
		@(posedge clk);
		#1;
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		@(negedge clk);
		while (!awready) @(negedge clk);
		checks++;
		if (wready !== 1'b1) begin
			$display("mismatch wready: got 0x%h expected 0x1", wready);
			errors++;
		end
		@(posedge clk);
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		@(negedge clk);
		while (!bvalid) @(negedge clk);
		checks++;
		if (bresp !== respOkay) begin
			$display("mismatch bresp: got 0x%h expected 0x%h", bresp, respOkay);
			errors++;
		end
		@(posedge clk);
		#1;
		bready = 1'b1;
		@(posedge clk);
		#1;
		bready = 1'b0;
	endtask

	task automatic axiRead(input logic [axiAddrWidth-1:0] addr,
			output logic [axiDataWidth-1:0] data);
		@(posedge clk);
		#1;
		araddr = addr;
		arvalid = 1'b1;
		@(negedge clk);
		while (!arready) @(negedge clk);
		@(posedge clk);
		#1;
		arvalid = 1'b0;
		@(negedge clk);
		while (!rvalid) @(negedge clk);
		data = rdata;
		checks++;
		if (rresp !== respOkay) begin
			$display("mismatch rresp: got 0x%h expected 0x%h", rresp, respOkay);
			errors++;
		end
		@(posedge clk);
		#1;
		rready = 1'b1;
		@(posedge clk);
		#1;
		rready = 1'b0;
	endtask

	task automatic checkStatusCount();
		logic [axiDataWidth-1:0] status;
		axiRead(addrStatus, status);
		checks++;
		if (status[countWidth-1:0] > queueDepth) begin
			$display("mismatch status count: got 0x%h, above depth 0x%h",
				status[countWidth-1:0], countWidth'(queueDepth));
			errors++;
		end
	endtask

	task automatic checkRegs();
		logic [axiDataWidth-1:0] status;
		logic [axiDataWidth-1:0] data;
		axiRead(addrStatus, status);
		while (!status[statusIdleBit]) axiRead(addrStatus, status);
		for (int i = 0; i < regCount; i++) begin
			axiRead(addrRegBase + 8'(4 * i), data);
			checks++;
			if (data[dataWidth-1:0] !== modelReg[i]) begin
				$display("mismatch rdata r%0d: got 0x%h expected 0x%h",
					i, data[dataWidth-1:0], modelReg[i]);
				errors++;
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence

	initial begin
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '1;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		arstN = 1'b0;
		for (int i = 0; i < regCount; i++) begin
			modelReg[i] = '0;
			modelMem[i] = '0;
		end
		buildProgram();
		checkPoints = 0;
		foreach (progTable[i]) begin
			if (progTable[i].check) checkPoints++;
		end
		// a write is about 4 cycles, a register dump about 90
		cycleLimit = 20 + progTable.size() * 12 + checkPoints * 150;

		repeat (10) @(posedge clk);
		#1;
		arstN = 1'b1;

		idx = 0;
		testNum = 0;
		while (idx < progTable.size()) begin
			errorsBefore = errors;
			writing = 1'b1;
			fork
				begin
					do begin
						axiWrite(addrInstPush, 32'(progTable[idx].inst));
						applyModel(progTable[idx].inst);
						idx++;
					end while (!progTable[idx-1].check);
					writing = 1'b0;
				end
				begin
					while (writing) checkStatusCount();
				end
			join
			checkRegs();
			if (errors == errorsBefore) begin
				$display("test %0d %s: ok", testNum + 1, testNames[testNum]);
			end else begin
				$display("test %0d %s: %0d errors", testNum + 1, testNames[testNum],
					errors - errorsBefore);
			end
			testNum++;
		end

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

//--- cr16Top_assert.sv
`timescale 1ns/1ps

module cr16TopAssert (
	input logic clk,
	input logic arstN,
	input logic bvalid,
	input logic bready,
	input logic rvalid,
	input logic rready,
	input logic pushValid,
	input logic full,
	input logic pop,
	input logic empty
);

	//////////////////////////////////////////////////////////////////////
	// host bus responses stay up until taken

	assert property (@(posedge clk) disable iff (!arstN) bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	assert property (@(posedge clk) disable iff (!arstN) rvalid && !rready |=> rvalid)
		else $error("rvalid dropped before rready");

	//////////////////////////////////////////////////////////////////////
	// queue handshakes

	assert property (@(posedge clk) disable iff (!arstN) pushValid |-> !full)
		else $error("push while the queue is full");

	assert property (@(posedge clk) disable iff (!arstN) pop |-> !empty)
		else $error("pop while the queue is empty");

endmodule

//--- cr16Top.sv
`timescale 1ns/1ps

module cr16Top (
	input logic clk,
	input logic arstN,
	input logic [cr16Pkg::axiAddrWidth-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [cr16Pkg::axiDataWidth-1:0] wdata,
	input logic [cr16Pkg::axiDataWidth/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output cr16Pkg::axiResp bresp,
	output logic bvalid,
	input logic bready,
	input logic [cr16Pkg::axiAddrWidth-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [cr16Pkg::axiDataWidth-1:0] rdata,
	output cr16Pkg::axiResp rresp,
	output logic rvalid,
	input logic rready
);
	import cr16Pkg::*;

	logic pushValid;
	instWord pushData;
	logic full;
	logic empty;
	logic pop;
	logic [countWidth-1:0] count;
	instWord popData;
	logic [regAddrWidth-1:0] regIndex;
	logic [dataWidth-1:0] regData;
	logic coreBusy;

	// producer
	cr16AxiSlave axiSlave (
		.clk(clk),
		.arstN(arstN),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.pushValid(pushValid),
		.pushData(pushData),
		.full(full),
		.count(count),
		.regIndex(regIndex),
		.regData(regData),
		.coreBusy(coreBusy)
	);

	// buffer
	instQueue queue (
		.clk(clk),
		.arstN(arstN),
		.pushValid(pushValid),
		.pushData(pushData),
		.pop(pop),
		.popData(popData),
		.empty(empty),
		.full(full),
		.count(count)
	);

	// consumer
	execCore core (
		.clk(clk),
		.arstN(arstN),
		.popData(popData),
		.empty(empty),
		.pop(pop),
		.regIndex(regIndex),
		.regData(regData),
		.coreBusy(coreBusy)
	);

endmodule

//--- cr16AxiSlave.sv
`timescale 1ns/1ps

module cr16AxiSlave (
	input logic clk,
	input logic arstN,
	// write address and data
	input logic [cr16Pkg::axiAddrWidth-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [cr16Pkg::axiDataWidth-1:0] wdata,
	input logic [cr16Pkg::axiDataWidth/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	// write response
	output cr16Pkg::axiResp bresp,
	output logic bvalid,
	input logic bready,
	// read channels
	input logic [cr16Pkg::axiAddrWidth-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [cr16Pkg::axiDataWidth-1:0] rdata,
	output cr16Pkg::axiResp rresp,
	output logic rvalid,
	input logic rready,
	// queue side
	output logic pushValid,
	output cr16Pkg::instWord pushData,
	input logic full,
	input logic [cr16Pkg::countWidth-1:0] count,
	// core side
	output logic [cr16Pkg::regAddrWidth-1:0] regIndex,
	input logic [cr16Pkg::dataWidth-1:0] regData,
	input logic coreBusy
);
	import cr16Pkg::*;

	logic writeAccept;
	logic readAccept;
	logic [axiAddrWidth-1:0] regOffset;
	logic [axiDataWidth-1:0] statusWord;
	logic [axiDataWidth-1:0] readWord;

	//////////////////////////////////////////////////////////////////////
	// write path

	// address and data taken together, held off by a full queue
	assign writeAccept = awvalid && wvalid && !full && !bvalid;
	assign awready = writeAccept;
	assign wready = writeAccept;

	// other addresses complete normally but push nothing
	assign pushValid = writeAccept && (awaddr == addrInstPush);
	assign pushData = wdata[instWidth-1:0];

	assign bresp = respOkay;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			bvalid <= 1'b0;
		end else if (writeAccept) begin
			bvalid <= 1'b1;
		end else if (bready) begin
			bvalid <= 1'b0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// read path

	assign arready = !rvalid;
	assign readAccept = arvalid && arready;
	assign rresp = respOkay;

	assign regOffset = araddr - addrRegBase;
	assign regIndex = regOffset[2 +: regAddrWidth];

	always_comb begin
		statusWord = '0;
		statusWord[countWidth-1:0] = count;
		// idle once nothing is queued and nothing retires
		statusWord[statusIdleBit] = (count == '0) && !coreBusy;
	end

	always_comb begin
		readWord = '0;
		if (araddr == addrStatus) begin
			readWord = statusWord;
		end else if (araddr >= addrRegBase && araddr < addrRegBase + 4 * regCount) begin
			readWord[dataWidth-1:0] = regData;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			rvalid <= 1'b0;
		end else if (readAccept) begin
			rvalid <= 1'b1;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

	// data held until the host takes it
	always_ff @(posedge clk) begin
		if (readAccept) begin
			rdata <= readWord;
		end
	end

endmodule

//--- execCore.sv
`timescale 1ns/1ps

module execCore (
	input logic clk,
	input logic arstN,
	input cr16Pkg::instWord popData,
	input logic empty,
	output logic pop,
	input logic [cr16Pkg::regAddrWidth-1:0] regIndex,
	output logic [cr16Pkg::dataWidth-1:0] regData,
	output logic coreBusy
);
	import cr16Pkg::*;

	decodedInst ctrl;
	logic [dataWidth-1:0] regFile [regCount];
	logic [dataWidth-1:0] dataMem [memDepth];
	logic [dataWidth-1:0] opA;
	logic [dataWidth-1:0] regB;
	logic [dataWidth-1:0] opB;
	logic [dataWidth-1:0] shiftCount;
	logic [dataWidth-1:0] aluResult;
	logic [dataWidth-1:0] writeData;
	logic [memAddrWidth-1:0] memAddr;

	instDecoder decoder (
		.inst(popData),
		.ctrl(ctrl)
	);

	// one instruction per cycle whenever something is queued
	assign pop = !empty;
	assign coreBusy = pop;

	assign regData = regFile[regIndex];

	//////////////////////////////////////////////////////////////////////
	// operands

	assign opA = regFile[ctrl.srcA];
	assign regB = regFile[ctrl.srcB];
	assign opB = ctrl.useImm ? ctrl.immValue : regB;
	assign memAddr = regB[memAddrWidth-1:0];

	// negative count on lsh means shift right
	assign shiftCount = opB[dataWidth-1] ? -opB : opB;

	always_comb begin
		case (ctrl.aluOp)
			aluAdd: aluResult = opA + opB;
			aluSub: aluResult = opA - opB;
			aluAnd: aluResult = opA & opB;
			aluOr: aluResult = opA | opB;
			aluXor: aluResult = opA ^ opB;
			// not of the source operand
			aluNot: aluResult = ~opB;
			aluMov: aluResult = opB;
			aluLsh: aluResult = opB[dataWidth-1] ? opA >> shiftCount : opA << shiftCount;
			aluRsh: aluResult = opA >> opB;
			aluAlsh: aluResult = opA << opB;
			aluArsh: aluResult = $signed(opA) >>> opB;
			default: aluResult = opB;
		endcase
	end

	// load reads memory in the same cycle
	assign writeData = ctrl.loadMem ? dataMem[memAddr] : aluResult;

	//////////////////////////////////////////////////////////////////////
	// register file and data memory

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < regCount; i++) begin
				regFile[i] <= '0;
			end
			for (int j = 0; j < memDepth; j++) begin
				dataMem[j] <= '0;
			end
		end else if (pop) begin
			if (ctrl.writeReg) begin
				regFile[ctrl.destReg] <= writeData;
			end
			// stor sends the destination register's value
			if (ctrl.storeMem) begin
				dataMem[memAddr] <= opA;
			end
		end
	end

endmodule

//--- instDecoder.sv
`timescale 1ns/1ps

module instDecoder (
	input cr16Pkg::instWord inst,
	output cr16Pkg::decodedInst ctrl
);
	import cr16Pkg::*;

	logic [dataWidth-1:0] immSigned;
	logic [dataWidth-1:0] immUnsigned;
	logic [dataWidth-1:0] immUpper;
	logic [dataWidth-1:0] immShift;
	logic [dataWidth-1:0] immLiteral;

	// extended forms of the low byte
	assign immSigned = {{8{inst.i.imm[7]}}, inst.i.imm};
	assign immUnsigned = {8'h00, inst.i.imm};
	assign immUpper = {inst.i.imm, 8'h00};
	assign immShift = {12'h000, inst.r.src};
	assign immLiteral = {inst.i.op, inst.i.dest, inst.i.imm};

	always_comb begin
		// defaults, no write and no memory access
		ctrl = '0;
		ctrl.aluOp = aluMov;
		ctrl.srcA = inst.r.dest;
		ctrl.srcB = inst.r.src;
		ctrl.destReg = inst.r.dest;

		if (inst.r.cls == 2'b11) begin
			ctrl.immValue = immLiteral;
			ctrl.useImm = 1'b1;
			ctrl.writeReg = 1'b1;
		end else if (inst.r.cls == 2'b00) begin
			case (inst.r.op)
				////////////////////////////////////////////////////////////
				opRtype: begin
					ctrl.writeReg = 1'b1;
					case (inst.r.ext)
						extAdd, extAddu, extAddc, extAddcu: ctrl.aluOp = aluAdd;
						extSub: ctrl.aluOp = aluSub;
						extCmp: begin
							ctrl.aluOp = aluSub;
							ctrl.writeReg = 1'b0;
						end
						extAnd: ctrl.aluOp = aluAnd;
						extOr: ctrl.aluOp = aluOr;
						extXor: ctrl.aluOp = aluXor;
						extNot: ctrl.aluOp = aluNot;
						extMov: ctrl.aluOp = aluMov;
						default: ctrl.writeReg = 1'b0;
					endcase
				end
				opShift: begin
					ctrl.writeReg = 1'b1;
					case (inst.r.ext)
						extLsh: ctrl.aluOp = aluLsh;
						extLshi: begin
							ctrl.aluOp = aluLsh;
							ctrl.immValue = immShift;
							ctrl.useImm = 1'b1;
						end
						extRsh: ctrl.aluOp = aluRsh;
						extRshi: begin
							ctrl.aluOp = aluRsh;
							ctrl.immValue = immShift;
							ctrl.useImm = 1'b1;
						end
						extAlsh: ctrl.aluOp = aluAlsh;
						extArsh: ctrl.aluOp = aluArsh;
						default: ctrl.writeReg = 1'b0;
					endcase
				end
				// address comes from the source register
				opMem: begin
					case (inst.r.ext)
						extLoad: begin
							ctrl.loadMem = 1'b1;
							ctrl.writeReg = 1'b1;
						end
						extStor: ctrl.storeMem = 1'b1;
						default: ctrl.writeReg = 1'b0;
					endcase
				end
				////////////////////////////////////////////////////////////
				opAddi, opAddci: begin
					ctrl.aluOp = aluAdd;
					ctrl.immValue = immSigned;
					ctrl.useImm = 1'b1;
					ctrl.writeReg = 1'b1;
				end
				opAddui, opAddcui: begin
					ctrl.aluOp = aluAdd;
					ctrl.immValue = immUnsigned;
					ctrl.useImm = 1'b1;
					ctrl.writeReg = 1'b1;
				end
				opSubi: begin
					ctrl.aluOp = aluSub;
					ctrl.immValue = immSigned;
					ctrl.useImm = 1'b1;
					ctrl.writeReg = 1'b1;
				end
				// compares compute but never write
				opCmpi: begin
					ctrl.aluOp = aluSub;
					ctrl.immValue = immSigned;
					ctrl.useImm = 1'b1;
				end
				opCmpui: begin
					ctrl.aluOp = aluSub;
					ctrl.immValue = immUnsigned;
					ctrl.useImm = 1'b1;
				end
				opMovi: begin
					ctrl.immValue = immUnsigned;
					ctrl.useImm = 1'b1;
					ctrl.writeReg = 1'b1;
				end
				opLui: begin
					ctrl.immValue = immUpper;
					ctrl.useImm = 1'b1;
					ctrl.writeReg = 1'b1;
				end
				default: ctrl.writeReg = 1'b0;
			endcase
		end
	end

endmodule

//--- instQueue.sv
`timescale 1ns/1ps

module instQueue (
	input logic clk,
	input logic arstN,
	input logic pushValid,
	input cr16Pkg::instWord pushData,
	input logic pop,
	output cr16Pkg::instWord popData,
	output logic empty,
	output logic full,
	output logic [cr16Pkg::countWidth-1:0] count
);
	import cr16Pkg::*;

	instWord slots [queueDepth];
	logic [queuePtrWidth-1:0] wrPtr;
	logic [queuePtrWidth-1:0] rdPtr;
	logic pushOk;
	logic popOk;

	// push while full is dropped here
	assign pushOk = pushValid && !full;
	assign popOk = pop && !empty;

	assign empty = (count == '0);
	assign full = (count == queueDepth);
	assign popData = slots[rdPtr];

	always_ff @(posedge clk) begin
		if (pushOk) begin
			slots[wrPtr] <= pushData;
		end
	end

	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (pushOk) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (popOk) begin
				rdPtr <= rdPtr + 1'b1;
			end
			case ({pushOk, popOk})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- cr16Pkg.sv
package cr16Pkg;

	// word and storage sizes
	localparam int instWidth = 18;
	localparam int dataWidth = 16;
	localparam int regCount = 16;
	localparam int regAddrWidth = $clog2(regCount);
	localparam int memDepth = 16;
	localparam int memAddrWidth = $clog2(memDepth);
	localparam int queueDepth = 8;
	localparam int queuePtrWidth = $clog2(queueDepth);
	localparam int countWidth = $clog2(queueDepth + 1);

	//////////////////////////////////////////////////////////////////////
	// major opcodes, bits 15:12
	localparam logic [3:0] opRtype = 4'b0000;
	localparam logic [3:0] opMem = 4'b0100;
	localparam logic [3:0] opAddi = 4'b0101;
	localparam logic [3:0] opAddui = 4'b0110;
	localparam logic [3:0] opAddci = 4'b0111;
	localparam logic [3:0] opShift = 4'b1000;
	localparam logic [3:0] opSubi = 4'b1001;
	localparam logic [3:0] opAddcui = 4'b1010;
	localparam logic [3:0] opCmpi = 4'b1011;
	localparam logic [3:0] opMovi = 4'b1101;
	localparam logic [3:0] opCmpui = 4'b1110;
	localparam logic [3:0] opLui = 4'b1111;

	// extension codes, bits 7:4, register forms
	localparam logic [3:0] extAnd = 4'b0001;
	localparam logic [3:0] extOr = 4'b0010;
	localparam logic [3:0] extXor = 4'b0011;
	localparam logic [3:0] extAddcu = 4'b0100;
	localparam logic [3:0] extAdd = 4'b0101;
	localparam logic [3:0] extAddu = 4'b0110;
	localparam logic [3:0] extAddc = 4'b0111;
	localparam logic [3:0] extSub = 4'b1001;
	localparam logic [3:0] extCmp = 4'b1011;
	localparam logic [3:0] extMov = 4'b1101;
	localparam logic [3:0] extNot = 4'b1111;

	// shift group
	localparam logic [3:0] extLshi = 4'b0000;
	localparam logic [3:0] extRshi = 4'b0001;
	localparam logic [3:0] extLsh = 4'b0100;
	localparam logic [3:0] extAlsh = 4'b0101;
	localparam logic [3:0] extRsh = 4'b1100;
	localparam logic [3:0] extArsh = 4'b1101;

	// memory group
	localparam logic [3:0] extLoad = 4'b0000;
	localparam logic [3:0] extStor = 4'b0100;

	// internal alu selects, named after the register form
	localparam logic [7:0] aluAdd = {opRtype, extAdd};
	localparam logic [7:0] aluSub = {opRtype, extSub};
	localparam logic [7:0] aluAnd = {opRtype, extAnd};
	localparam logic [7:0] aluOr = {opRtype, extOr};
	localparam logic [7:0] aluXor = {opRtype, extXor};
	localparam logic [7:0] aluNot = {opRtype, extNot};
	localparam logic [7:0] aluMov = {opRtype, extMov};
	localparam logic [7:0] aluLsh = {opShift, extLsh};
	localparam logic [7:0] aluRsh = {opShift, extRsh};
	localparam logic [7:0] aluAlsh = {opShift, extAlsh};
	localparam logic [7:0] aluArsh = {opShift, extArsh};

	//////////////////////////////////////////////////////////////////////
	// one instruction word, two field layouts
	typedef struct packed {
		logic [1:0] cls;
		logic [3:0] op;
		logic [3:0] dest;
		logic [3:0] ext;
		logic [3:0] src;
	} instRegForm;

	typedef struct packed {
		logic [1:0] cls;
		logic [3:0] op;
		logic [3:0] dest;
		logic [7:0] imm;
	} instImmForm;

	typedef union packed {
		instRegForm r;
		instImmForm i;
	} instWord;

	typedef struct packed {
		logic [7:0] aluOp;
		logic [dataWidth-1:0] immValue;
		logic useImm;
		logic writeReg;
		logic loadMem;
		logic storeMem;
		logic [regAddrWidth-1:0] srcA;
		logic [regAddrWidth-1:0] srcB;
		logic [regAddrWidth-1:0] destReg;
	} decodedInst;

	//////////////////////////////////////////////////////////////////////
	// host bus map
	localparam int axiAddrWidth = 8;
	localparam int axiDataWidth = 32;
	localparam logic [axiAddrWidth-1:0] addrInstPush = 8'h00;
	localparam logic [axiAddrWidth-1:0] addrStatus = 8'h04;
	localparam logic [axiAddrWidth-1:0] addrRegBase = 8'h40;
	localparam int statusIdleBit = 8;

	typedef logic [1:0] axiResp;
	localparam axiResp respOkay = 2'b00;

endpackage
